// File: verilog/cpu_pkg.sv
package cpu_pkg;

	localparam int WORD_W = 32;
	localparam int REG_ADDR_W = 5;
	localparam int MASK_W = 4;

	localparam int RAM_WORDS = 256;
	localparam int RAM_ADDR_W = 8; // Word index taken from address bits 9 down to 2

	typedef enum logic [3:0] {
		OP_NONE = 4'd0,
		OP_LB   = 4'd1,
		OP_LBU  = 4'd2,
		OP_LH   = 4'd3,
		OP_LHU  = 4'd4,
		OP_LW   = 4'd5,
		OP_LWL  = 4'd6,
		OP_LWR  = 4'd7,
		OP_LL   = 4'd8,
		OP_SB   = 4'd9,
		OP_SH   = 4'd10,
		OP_SW   = 4'd11,
		OP_SC   = 4'd12
	} mem_op_e;

endpackage

// File: verilog/mem_stage_reg.sv
`timescale 1ns/1ns

module mem_stage_reg (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              stall_i,

	input  cpu_pkg::mem_op_e                  a_op_i,
	input  logic                              a_ce_i,
	input  logic                              a_we_i,
	input  logic [cpu_pkg::WORD_W-1:0]        a_addr_i,
	input  logic [cpu_pkg::WORD_W-1:0]        a_wdata_i,
	input  logic [cpu_pkg::MASK_W-1:0]        a_sel_i,
	input  logic                              a_reg_we_i,
	input  logic [cpu_pkg::REG_ADDR_W-1:0]    a_reg_waddr_i,
	input  logic [cpu_pkg::WORD_W-1:0]        a_reg_wdata_i,

	input  cpu_pkg::mem_op_e                  b_op_i,
	input  logic                              b_ce_i,
	input  logic                              b_we_i,
	input  logic [cpu_pkg::WORD_W-1:0]        b_addr_i,
	input  logic [cpu_pkg::WORD_W-1:0]        b_wdata_i,
	input  logic [cpu_pkg::MASK_W-1:0]        b_sel_i,
	input  logic                              b_reg_we_i,
	input  logic [cpu_pkg::REG_ADDR_W-1:0]    b_reg_waddr_i,
	input  logic [cpu_pkg::WORD_W-1:0]        b_reg_wdata_i,

	output cpu_pkg::mem_op_e                  m_a_op_o,
	output logic                              m_a_ce_o,
	output logic                              m_a_we_o,
	output logic [cpu_pkg::WORD_W-1:0]        m_a_addr_o,
	output logic [cpu_pkg::WORD_W-1:0]        m_a_wdata_o,
	output logic [cpu_pkg::MASK_W-1:0]        m_a_sel_o,
	output logic                              m_a_reg_we_o,
	output logic [cpu_pkg::REG_ADDR_W-1:0]    m_a_reg_waddr_o,
	output logic [cpu_pkg::WORD_W-1:0]        m_a_reg_wdata_o,

	output cpu_pkg::mem_op_e                  m_b_op_o,
	output logic                              m_b_ce_o,
	output logic                              m_b_we_o,
	output logic [cpu_pkg::WORD_W-1:0]        m_b_addr_o,
	output logic [cpu_pkg::WORD_W-1:0]        m_b_wdata_o,
	output logic [cpu_pkg::MASK_W-1:0]        m_b_sel_o,
	output logic                              m_b_reg_we_o,
	output logic [cpu_pkg::REG_ADDR_W-1:0]    m_b_reg_waddr_o,
	output logic [cpu_pkg::WORD_W-1:0]        m_b_reg_wdata_o
);

always_ff @(posedge clk)
begin
	if (rst)
	begin
		m_a_op_o     <= cpu_pkg::OP_NONE;
		m_a_ce_o     <= 1'b0;
		m_a_we_o     <= 1'b0;
		m_a_reg_we_o <= 1'b0;
		m_b_op_o     <= cpu_pkg::OP_NONE;
		m_b_ce_o     <= 1'b0;
		m_b_we_o     <= 1'b0;
		m_b_reg_we_o <= 1'b0;
	end else if (!stall_i) begin // Hold the request until the RAM lets go
		m_a_op_o     <= a_op_i;
		m_a_ce_o     <= a_ce_i;
		m_a_we_o     <= a_we_i;
		m_a_reg_we_o <= a_reg_we_i;
		m_b_op_o     <= b_op_i;
		m_b_ce_o     <= b_ce_i;
		m_b_we_o     <= b_we_i;
		m_b_reg_we_o <= b_reg_we_i;
	end
end

always_ff @(posedge clk)
begin
	if (!stall_i)
	begin
		m_a_addr_o      <= a_addr_i;
		m_a_wdata_o     <= a_wdata_i;
		m_a_sel_o       <= a_sel_i;
		m_a_reg_waddr_o <= a_reg_waddr_i;
		m_a_reg_wdata_o <= a_reg_wdata_i;
		m_b_addr_o      <= b_addr_i;
		m_b_wdata_o     <= b_wdata_i;
		m_b_sel_o       <= b_sel_i;
		m_b_reg_waddr_o <= b_reg_waddr_i;
		m_b_reg_wdata_o <= b_reg_wdata_i;
	end
end

// A memory opcode reaching the stage without its request bit would be silently dropped
a_op_needs_ce: assert property (@(posedge clk) disable iff (rst)
	!m_a_ce_o |-> m_a_op_o == cpu_pkg::OP_NONE);
b_op_needs_ce: assert property (@(posedge clk) disable iff (rst)
	!m_b_ce_o |-> m_b_op_o == cpu_pkg::OP_NONE);

endmodule

// File: verilog/mem_access.sv
`timescale 1ns/1ns

module mem_access (
	input  logic                              rst_i,

	input  cpu_pkg::mem_op_e                  m_a_op_i,
	input  logic                              m_a_ce_i,
	input  logic                              m_a_we_i,
	input  logic [cpu_pkg::WORD_W-1:0]        m_a_addr_i,
	input  logic [cpu_pkg::WORD_W-1:0]        m_a_wdata_i,
	input  logic [cpu_pkg::MASK_W-1:0]        m_a_sel_i,
	input  logic                              m_a_reg_we_i,
	input  logic [cpu_pkg::REG_ADDR_W-1:0]    m_a_reg_waddr_i,
	input  logic [cpu_pkg::WORD_W-1:0]        m_a_reg_wdata_i,

	input  cpu_pkg::mem_op_e                  m_b_op_i,
	input  logic                              m_b_ce_i,
	input  logic                              m_b_we_i,
	input  logic [cpu_pkg::WORD_W-1:0]        m_b_addr_i,
	input  logic [cpu_pkg::WORD_W-1:0]        m_b_wdata_i,
	input  logic [cpu_pkg::MASK_W-1:0]        m_b_sel_i,
	input  logic                              m_b_reg_we_i,
	input  logic [cpu_pkg::REG_ADDR_W-1:0]    m_b_reg_waddr_i,
	input  logic [cpu_pkg::WORD_W-1:0]        m_b_reg_wdata_i,

	input  logic                              ll_bit_i,
	input  logic [cpu_pkg::WORD_W-1:0]        bus_rdata_i,

	output logic [cpu_pkg::WORD_W-1:0]        bus_addr_o,
	output logic                              bus_read_o,
	output logic                              bus_write_o,
	output logic [cpu_pkg::WORD_W-1:0]        bus_wdata_o,
	output logic [cpu_pkg::MASK_W-1:0]        bus_mask_o,

	output cpu_pkg::mem_op_e                  sel_op_o,
	output logic                              res_a_we_o,
	output logic [cpu_pkg::REG_ADDR_W-1:0]    res_a_waddr_o,
	output logic [cpu_pkg::WORD_W-1:0]        res_a_wdata_o,
	output logic                              res_b_we_o,
	output logic [cpu_pkg::REG_ADDR_W-1:0]    res_b_waddr_o,
	output logic [cpu_pkg::WORD_W-1:0]        res_b_wdata_o
);

cpu_pkg::mem_op_e op;
logic sel_b;
logic ce;
logic we;
logic [cpu_pkg::WORD_W-1:0] addr;
logic [cpu_pkg::WORD_W-1:0] wdata;
logic [cpu_pkg::MASK_W-1:0] sel;
logic reg_we;
logic [cpu_pkg::REG_ADDR_W-1:0] reg_waddr;
logic [cpu_pkg::WORD_W-1:0] reg_wdata;

logic mem_we;
logic [cpu_pkg::WORD_W-1:0] mem_wdata;

logic [1:0] offset;
logic [cpu_pkg::WORD_W-1:0] ext_mask;
logic [cpu_pkg::WORD_W-1:0] aligned_rd;
logic [cpu_pkg::WORD_W-1:0] unaligned_rd;
logic [cpu_pkg::WORD_W-1:0] merged_rd;

assign sel_b = m_b_ce_i; // Pipe b owns the bus whenever it asks

always_comb
begin
	if (sel_b)
	begin
		op        = m_b_op_i;
		ce        = m_b_ce_i;
		we        = m_b_we_i;
		addr      = m_b_addr_i;
		wdata     = m_b_wdata_i;
		sel       = m_b_sel_i;
		reg_we    = m_b_reg_we_i;
		reg_waddr = m_b_reg_waddr_i;
		reg_wdata = m_b_reg_wdata_i;
	end else begin
		op        = m_a_op_i;
		ce        = m_a_ce_i;
		we        = m_a_we_i;
		addr      = m_a_addr_i;
		wdata     = m_a_wdata_i;
		sel       = m_a_sel_i;
		reg_we    = m_a_reg_we_i;
		reg_waddr = m_a_reg_waddr_i;
		reg_wdata = m_a_reg_wdata_i;
	end
end

assign sel_op_o = op;

assign offset = addr[1:0];
assign ext_mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
assign aligned_rd = bus_rdata_i >> {offset, 3'b000};
assign unaligned_rd = (op == cpu_pkg::OP_LWL) ? bus_rdata_i << {~offset, 3'b000} : aligned_rd;
assign merged_rd = (wdata & ~ext_mask) | (unaligned_rd & ext_mask); // Old rt arrives as wdata

always_comb
begin
	bus_addr_o  = '0;
	bus_read_o  = 1'b0;
	bus_write_o = 1'b0;
	bus_wdata_o = '0;
	bus_mask_o  = '0;
	mem_we      = reg_we;
	mem_wdata   = reg_wdata;
	if (ce && we)
	begin
		bus_addr_o  = {addr[cpu_pkg::WORD_W-1:2], 2'b00};
		bus_write_o = 1'b1;
		bus_wdata_o = wdata;
		bus_mask_o  = sel;
		if (op == cpu_pkg::OP_SC)
		begin
			bus_write_o = ll_bit_i; // A lost reservation leaves memory alone
			mem_wdata   = {{(cpu_pkg::WORD_W-1){1'b0}}, ll_bit_i};
		end else begin
			mem_we = 1'b0;
		end
	end else if (ce) begin
		bus_addr_o = {addr[cpu_pkg::WORD_W-1:2], 2'b00};
		bus_read_o = 1'b1;
		bus_mask_o = sel;
		mem_we     = 1'b1;
		case (op)
			cpu_pkg::OP_LB:  mem_wdata = {{24{aligned_rd[7]}}, aligned_rd[7:0]};
			cpu_pkg::OP_LBU: mem_wdata = {24'b0, aligned_rd[7:0]};
			cpu_pkg::OP_LH:  mem_wdata = {{16{aligned_rd[15]}}, aligned_rd[15:0]};
			cpu_pkg::OP_LHU: mem_wdata = {16'b0, aligned_rd[15:0]};
			cpu_pkg::OP_LWL, cpu_pkg::OP_LWR: mem_wdata = merged_rd;
			default: mem_wdata = aligned_rd;
		endcase
	end
	if (rst_i)
	begin
		bus_read_o  = 1'b0;
		bus_write_o = 1'b0;
	end
end

always_comb
begin
	res_a_we_o    = m_a_reg_we_i;
	res_a_waddr_o = m_a_reg_waddr_i;
	res_a_wdata_o = m_a_reg_wdata_i;
	res_b_we_o    = m_b_reg_we_i;
	res_b_waddr_o = m_b_reg_waddr_i;
	res_b_wdata_o = m_b_reg_wdata_i;
	if (sel_b)
	begin
		res_b_we_o    = mem_we;
		res_b_waddr_o = reg_waddr;
		res_b_wdata_o = mem_wdata;
	end else begin
		res_a_we_o    = mem_we;
		res_a_waddr_o = reg_waddr;
		res_a_wdata_o = mem_wdata;
	end
	if (rst_i)
	begin
		res_a_we_o = 1'b0;
		res_b_we_o = 1'b0;
	end
end

// The issue logic must never hand both pipes a memory slot at once
always_comb
begin
	if (!rst_i)
	begin
		one_mem_pipe: assert final (!(m_a_ce_i && m_b_ce_i));
	end
end

endmodule

// File: verilog/data_ram.sv
`timescale 1ns/1ns

module data_ram (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [cpu_pkg::WORD_W-1:0]    addr_i,
	input  logic                          read_i,
	input  logic                          write_i,
	input  logic [cpu_pkg::WORD_W-1:0]    wdata_i,
	input  logic [cpu_pkg::MASK_W-1:0]    mask_i,
	output logic [cpu_pkg::WORD_W-1:0]    rdata_o,
	output logic                          stall_o
);

logic [cpu_pkg::WORD_W-1:0] mem [cpu_pkg::RAM_WORDS];
logic [cpu_pkg::RAM_ADDR_W-1:0] word_idx;
logic access;
logic waited;

assign word_idx = addr_i[cpu_pkg::RAM_ADDR_W+1:2];
assign access = read_i | write_i;

// First cycle of every access is the wait state
assign stall_o = access & ~waited;

always_ff @(posedge clk)
begin
	if (rst)
	begin
		waited <= 1'b0;
	end else begin
		waited <= stall_o; // Drops again as soon as the access is released
	end
end

always_ff @(posedge clk)
begin
	if (write_i && !stall_o)
	begin
		for (int i = 0; i < cpu_pkg::MASK_W; i++)
		begin
			if (mask_i[i])
			begin
				mem[word_idx][i*8 +: 8] <= wdata_i[i*8 +: 8];
			end
		end
	end
end

assign rdata_o = mem[word_idx];

// Read and write share one address port
no_read_write: assert property (@(posedge clk) disable iff (rst)
	!(read_i && write_i));

// An access is held through its second cycle
wait_one: assert property (@(posedge clk) disable iff (rst)
	stall_o |=> access);

endmodule

// File: verilog/wb_reg.sv
`timescale 1ns/1ns

module wb_reg (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              stall_i,

	input  cpu_pkg::mem_op_e                  sel_op_i,
	input  logic                              res_a_we_i,
	input  logic [cpu_pkg::REG_ADDR_W-1:0]    res_a_waddr_i,
	input  logic [cpu_pkg::WORD_W-1:0]        res_a_wdata_i,
	input  logic                              res_b_we_i,
	input  logic [cpu_pkg::REG_ADDR_W-1:0]    res_b_waddr_i,
	input  logic [cpu_pkg::WORD_W-1:0]        res_b_wdata_i,

	output logic                              wb_a_we_o,
	output logic [cpu_pkg::REG_ADDR_W-1:0]    wb_a_waddr_o,
	output logic [cpu_pkg::WORD_W-1:0]        wb_a_wdata_o,
	output logic                              wb_b_we_o,
	output logic [cpu_pkg::REG_ADDR_W-1:0]    wb_b_waddr_o,
	output logic [cpu_pkg::WORD_W-1:0]        wb_b_wdata_o,
	output logic                              ll_bit_o
);

always_ff @(posedge clk)
begin
	if (rst)
	begin
		wb_a_we_o <= 1'b0;
		wb_b_we_o <= 1'b0;
		ll_bit_o  <= 1'b0;
	end else if (stall_i) begin
		wb_a_we_o <= 1'b0; // Bubble so the held request is written only once
		wb_b_we_o <= 1'b0;
	end else begin
		wb_a_we_o <= res_a_we_i;
		wb_b_we_o <= res_b_we_i;
		if (sel_op_i == cpu_pkg::OP_LL)
		begin
			ll_bit_o <= 1'b1;
		end else if (sel_op_i == cpu_pkg::OP_SC) begin
			ll_bit_o <= 1'b0; // Any SC uses up the reservation
		end
	end
end

always_ff @(posedge clk)
begin
	if (!stall_i)
	begin
		wb_a_waddr_o <= res_a_waddr_i;
		wb_a_wdata_o <= res_a_wdata_i;
		wb_b_waddr_o <= res_b_waddr_i;
		wb_b_wdata_o <= res_b_wdata_i;
	end
end

endmodule

// File: verilog/mem_top.sv
`timescale 1ns/1ns

module mem_top (
	input  logic                              clk,
	input  logic                              rst,

	input  cpu_pkg::mem_op_e                  a_op_i,
	input  logic                              a_ce_i,
	input  logic                              a_we_i,
	input  logic [cpu_pkg::WORD_W-1:0]        a_addr_i,
	input  logic [cpu_pkg::WORD_W-1:0]        a_wdata_i,
	input  logic [cpu_pkg::MASK_W-1:0]        a_sel_i,
	input  logic                              a_reg_we_i,
	input  logic [cpu_pkg::REG_ADDR_W-1:0]    a_reg_waddr_i,
	input  logic [cpu_pkg::WORD_W-1:0]        a_reg_wdata_i,

	input  cpu_pkg::mem_op_e                  b_op_i,
	input  logic                              b_ce_i,
	input  logic                              b_we_i,
	input  logic [cpu_pkg::WORD_W-1:0]        b_addr_i,
	input  logic [cpu_pkg::WORD_W-1:0]        b_wdata_i,
	input  logic [cpu_pkg::MASK_W-1:0]        b_sel_i,
	input  logic                              b_reg_we_i,
	input  logic [cpu_pkg::REG_ADDR_W-1:0]    b_reg_waddr_i,
	input  logic [cpu_pkg::WORD_W-1:0]        b_reg_wdata_i,

	output logic                              stall_o,
	output logic                              wb_a_we_o,
	output logic [cpu_pkg::REG_ADDR_W-1:0]    wb_a_waddr_o,
	output logic [cpu_pkg::WORD_W-1:0]        wb_a_wdata_o,
	output logic                              wb_b_we_o,
	output logic [cpu_pkg::REG_ADDR_W-1:0]    wb_b_waddr_o,
	output logic [cpu_pkg::WORD_W-1:0]        wb_b_wdata_o
);

cpu_pkg::mem_op_e m_a_op;
logic m_a_ce;
logic m_a_we;
logic [cpu_pkg::WORD_W-1:0] m_a_addr;
logic [cpu_pkg::WORD_W-1:0] m_a_wdata;
logic [cpu_pkg::MASK_W-1:0] m_a_sel;
logic m_a_reg_we;
logic [cpu_pkg::REG_ADDR_W-1:0] m_a_reg_waddr;
logic [cpu_pkg::WORD_W-1:0] m_a_reg_wdata;

cpu_pkg::mem_op_e m_b_op;
logic m_b_ce;
logic m_b_we;
logic [cpu_pkg::WORD_W-1:0] m_b_addr;
logic [cpu_pkg::WORD_W-1:0] m_b_wdata;
logic [cpu_pkg::MASK_W-1:0] m_b_sel;
logic m_b_reg_we;
logic [cpu_pkg::REG_ADDR_W-1:0] m_b_reg_waddr;
logic [cpu_pkg::WORD_W-1:0] m_b_reg_wdata;

logic [cpu_pkg::WORD_W-1:0] bus_addr;
logic bus_read;
logic bus_write;
logic [cpu_pkg::WORD_W-1:0] bus_wdata;
logic [cpu_pkg::MASK_W-1:0] bus_mask;
logic [cpu_pkg::WORD_W-1:0] bus_rdata;
logic bus_stall;

cpu_pkg::mem_op_e sel_op;
logic res_a_we;
logic [cpu_pkg::REG_ADDR_W-1:0] res_a_waddr;
logic [cpu_pkg::WORD_W-1:0] res_a_wdata;
logic res_b_we;
logic [cpu_pkg::REG_ADDR_W-1:0] res_b_waddr;
logic [cpu_pkg::WORD_W-1:0] res_b_wdata;
logic ll_bit;

assign stall_o = bus_stall;

mem_stage_reg u_stage (
	.clk(clk), .rst(rst), .stall_i(bus_stall),
	.a_op_i(a_op_i), .a_ce_i(a_ce_i), .a_we_i(a_we_i), .a_addr_i(a_addr_i),
	.a_wdata_i(a_wdata_i), .a_sel_i(a_sel_i), .a_reg_we_i(a_reg_we_i),
	.a_reg_waddr_i(a_reg_waddr_i), .a_reg_wdata_i(a_reg_wdata_i),
	.b_op_i(b_op_i), .b_ce_i(b_ce_i), .b_we_i(b_we_i), .b_addr_i(b_addr_i),
	.b_wdata_i(b_wdata_i), .b_sel_i(b_sel_i), .b_reg_we_i(b_reg_we_i),
	.b_reg_waddr_i(b_reg_waddr_i), .b_reg_wdata_i(b_reg_wdata_i),
	.m_a_op_o(m_a_op), .m_a_ce_o(m_a_ce), .m_a_we_o(m_a_we), .m_a_addr_o(m_a_addr),
	.m_a_wdata_o(m_a_wdata), .m_a_sel_o(m_a_sel), .m_a_reg_we_o(m_a_reg_we),
	.m_a_reg_waddr_o(m_a_reg_waddr), .m_a_reg_wdata_o(m_a_reg_wdata),
	.m_b_op_o(m_b_op), .m_b_ce_o(m_b_ce), .m_b_we_o(m_b_we), .m_b_addr_o(m_b_addr),
	.m_b_wdata_o(m_b_wdata), .m_b_sel_o(m_b_sel), .m_b_reg_we_o(m_b_reg_we),
	.m_b_reg_waddr_o(m_b_reg_waddr), .m_b_reg_wdata_o(m_b_reg_wdata)
);

mem_access u_access (
	.rst_i(rst),
	.m_a_op_i(m_a_op), .m_a_ce_i(m_a_ce), .m_a_we_i(m_a_we), .m_a_addr_i(m_a_addr),
	.m_a_wdata_i(m_a_wdata), .m_a_sel_i(m_a_sel), .m_a_reg_we_i(m_a_reg_we),
	.m_a_reg_waddr_i(m_a_reg_waddr), .m_a_reg_wdata_i(m_a_reg_wdata),
	.m_b_op_i(m_b_op), .m_b_ce_i(m_b_ce), .m_b_we_i(m_b_we), .m_b_addr_i(m_b_addr),
	.m_b_wdata_i(m_b_wdata), .m_b_sel_i(m_b_sel), .m_b_reg_we_i(m_b_reg_we),
	.m_b_reg_waddr_i(m_b_reg_waddr), .m_b_reg_wdata_i(m_b_reg_wdata),
	.ll_bit_i(ll_bit), .bus_rdata_i(bus_rdata),
	.bus_addr_o(bus_addr), .bus_read_o(bus_read), .bus_write_o(bus_write),
	.bus_wdata_o(bus_wdata), .bus_mask_o(bus_mask), .sel_op_o(sel_op),
	.res_a_we_o(res_a_we), .res_a_waddr_o(res_a_waddr), .res_a_wdata_o(res_a_wdata),
	.res_b_we_o(res_b_we), .res_b_waddr_o(res_b_waddr), .res_b_wdata_o(res_b_wdata)
);

data_ram u_ram (
	.clk(clk), .rst(rst), .addr_i(bus_addr), .read_i(bus_read), .write_i(bus_write),
	.wdata_i(bus_wdata), .mask_i(bus_mask), .rdata_o(bus_rdata), .stall_o(bus_stall)
);

wb_reg u_wb (
	.clk(clk), .rst(rst), .stall_i(bus_stall), .sel_op_i(sel_op),
	.res_a_we_i(res_a_we), .res_a_waddr_i(res_a_waddr), .res_a_wdata_i(res_a_wdata),
	.res_b_we_i(res_b_we), .res_b_waddr_i(res_b_waddr), .res_b_wdata_i(res_b_wdata),
	.wb_a_we_o(wb_a_we_o), .wb_a_waddr_o(wb_a_waddr_o), .wb_a_wdata_o(wb_a_wdata_o),
	.wb_b_we_o(wb_b_we_o), .wb_b_waddr_o(wb_b_waddr_o), .wb_b_wdata_o(wb_b_wdata_o),
	.ll_bit_o(ll_bit)
);

endmodule

// File: bench/tb_mem_top.sv
`timescale 1ns/1ns

module tb_mem_top;

localparam int ALU_REQS = 10;
localparam int INIT_REQS = 18;
localparam int STORE_REQS = 24;
localparam int LOAD_DIR_REQS = 12;
localparam int LOAD_REQS = 24;
localparam int MERGE_REQS = 16;
localparam int LLSC_REQS = 4;
localparam int MIX_REQS = 16;
localparam int TOTAL_REQS = ALU_REQS + INIT_REQS + STORE_REQS + LOAD_DIR_REQS + LOAD_REQS
	+ MERGE_REQS + LLSC_REQS + MIX_REQS;
localparam int CYCLE_LIMIT = 3 * TOTAL_REQS + 100;

typedef struct packed {
	cpu_pkg::mem_op_e op;
	logic [cpu_pkg::REG_ADDR_W-1:0] waddr;
	logic [cpu_pkg::WORD_W-1:0] wdata;
} wb_exp_t;

logic clk;
logic rst;
cpu_pkg::mem_op_e a_op_i, b_op_i;
logic a_ce_i, a_we_i, a_reg_we_i, b_ce_i, b_we_i, b_reg_we_i;
logic [cpu_pkg::WORD_W-1:0] a_addr_i, a_wdata_i, a_reg_wdata_i;
logic [cpu_pkg::WORD_W-1:0] b_addr_i, b_wdata_i, b_reg_wdata_i;
logic [cpu_pkg::MASK_W-1:0] a_sel_i, b_sel_i;
logic [cpu_pkg::REG_ADDR_W-1:0] a_reg_waddr_i, b_reg_waddr_i;
logic stall_o;
logic wb_a_we_o, wb_b_we_o;
logic [cpu_pkg::REG_ADDR_W-1:0] wb_a_waddr_o, wb_b_waddr_o;
logic [cpu_pkg::WORD_W-1:0] wb_a_wdata_o, wb_b_wdata_o;

int seed = 11;
int cycles = 0;
int value_errs = 0;
int sc_errs = 0;
int flow_errs = 0;
int accesses = 0; // Memory accesses the model expects, one stall cycle each
int stall_pulses = 0;
logic stall_prev = 1'b0;
logic ll_model = 1'b0;
logic [cpu_pkg::WORD_W-1:0] mem_model [int];
wb_exp_t exp_a[$];
wb_exp_t exp_b[$];

mem_top dut (
	.clk(clk), .rst(rst),
	.a_op_i(a_op_i), .a_ce_i(a_ce_i), .a_we_i(a_we_i), .a_addr_i(a_addr_i),
	.a_wdata_i(a_wdata_i), .a_sel_i(a_sel_i), .a_reg_we_i(a_reg_we_i),
	.a_reg_waddr_i(a_reg_waddr_i), .a_reg_wdata_i(a_reg_wdata_i),
	.b_op_i(b_op_i), .b_ce_i(b_ce_i), .b_we_i(b_we_i), .b_addr_i(b_addr_i),
	.b_wdata_i(b_wdata_i), .b_sel_i(b_sel_i), .b_reg_we_i(b_reg_we_i),
	.b_reg_waddr_i(b_reg_waddr_i), .b_reg_wdata_i(b_reg_wdata_i),
	.stall_o(stall_o),
	.wb_a_we_o(wb_a_we_o), .wb_a_waddr_o(wb_a_waddr_o), .wb_a_wdata_o(wb_a_wdata_o),
	.wb_b_we_o(wb_b_we_o), .wb_b_waddr_o(wb_b_waddr_o), .wb_b_wdata_o(wb_b_wdata_o)
);

initial
begin
	clk = 1'b0;
	forever #4 clk = ~clk;
end

function automatic logic [31:0] next_rand();
	next_rand = $random(seed);
endfunction

function automatic cpu_pkg::mem_op_e op_from_index(input logic [31:0] k);
	case (k)
		0: op_from_index = cpu_pkg::OP_LB;
		1: op_from_index = cpu_pkg::OP_LBU;
		2: op_from_index = cpu_pkg::OP_LH;
		3: op_from_index = cpu_pkg::OP_LHU;
		4: op_from_index = cpu_pkg::OP_LW;
		5: op_from_index = cpu_pkg::OP_SB;
		6: op_from_index = cpu_pkg::OP_SH;
		default: op_from_index = cpu_pkg::OP_SW;
	endcase
endfunction

function automatic logic is_store(input cpu_pkg::mem_op_e op);
	is_store = op == cpu_pkg::OP_SB || op == cpu_pkg::OP_SH || op == cpu_pkg::OP_SW
		|| op == cpu_pkg::OP_SC;
endfunction

// Byte lanes a MIPS access touches, as the issue stage would compute them
function automatic logic [3:0] lane_mask(input cpu_pkg::mem_op_e op, input logic [1:0] off);
	case (op)
		cpu_pkg::OP_LB, cpu_pkg::OP_LBU, cpu_pkg::OP_SB: lane_mask = 4'b0001 << off;
		cpu_pkg::OP_LH, cpu_pkg::OP_LHU, cpu_pkg::OP_SH: lane_mask = off[1] ? 4'b1100 : 4'b0011;
		cpu_pkg::OP_LWL: lane_mask = 4'b1111 << (2'd3 - off); // Bytes 0 to off fill the top of rt
		cpu_pkg::OP_LWR: lane_mask = 4'b1111 >> off;
		default: lane_mask = 4'b1111;
	endcase
endfunction

function automatic logic [1:0] pick_offset(input cpu_pkg::mem_op_e op);
	logic [31:0] r;
	r = next_rand();
	case (op)
		cpu_pkg::OP_LH, cpu_pkg::OP_LHU, cpu_pkg::OP_SH: pick_offset = {r[0], 1'b0};
		cpu_pkg::OP_LW, cpu_pkg::OP_LL, cpu_pkg::OP_SW, cpu_pkg::OP_SC: pick_offset = 2'b00;
		default: pick_offset = r[1:0];
	endcase
endfunction

function automatic logic [31:0] ref_load(input cpu_pkg::mem_op_e op, input logic [31:0] addr,
	input logic [31:0] old_rt, input logic [3:0] mask);
	logic [31:0] word;
	logic [7:0] b;
	logic [15:0] h;
	int off;
	word = mem_model.exists(int'(addr[9:2])) ? mem_model[int'(addr[9:2])] : '0;
	off = int'(addr[1:0]);
	b = word[off*8 +: 8];
	h = {word[((off + 1) % 4)*8 +: 8], b};
	ref_load = word;
	case (op)
		cpu_pkg::OP_LB: ref_load = {{24{b[7]}}, b};
		cpu_pkg::OP_LBU: ref_load = {24'd0, b};
		cpu_pkg::OP_LH: ref_load = {{16{h[15]}}, h};
		cpu_pkg::OP_LHU: ref_load = {16'd0, h};
		cpu_pkg::OP_LWL:
		begin
			ref_load = old_rt;
			for (int i = 0; i < 4; i++)
			begin
				if (mask[i])
				begin
					ref_load[i*8 +: 8] = word[(i + off - 3)*8 +: 8]; // Byte off lands in lane 3
				end
			end
		end
		cpu_pkg::OP_LWR:
		begin
			ref_load = old_rt;
			for (int i = 0; i < 4; i++)
			begin
				if (mask[i])
				begin
					ref_load[i*8 +: 8] = word[(i + off)*8 +: 8]; // Byte off lands in lane 0
				end
			end
		end
		default: ref_load = word;
	endcase
endfunction

task automatic store_model(input logic [31:0] addr, input logic [31:0] wdata,
	input logic [3:0] mask);
	logic [31:0] word;
	word = mem_model.exists(int'(addr[9:2])) ? mem_model[int'(addr[9:2])] : '0;
	for (int i = 0; i < 4; i++)
	begin
		if (mask[i])
		begin
			word[i*8 +: 8] = wdata[i*8 +: 8];
		end
	end
	mem_model[int'(addr[9:2])] = word;
endtask

task automatic expect_write(input logic is_b, input cpu_pkg::mem_op_e op,
	input logic [4:0] waddr, input logic [31:0] wdata);
	wb_exp_t e;
	e.op = op;
	e.waddr = waddr;
	e.wdata = wdata;
	if (is_b)
	begin
		exp_b.push_back(e);
	end else begin
		exp_a.push_back(e);
	end
endtask

task automatic drive_pipe(input logic is_b, input cpu_pkg::mem_op_e op, input logic ce,
	input logic we, input logic [31:0] addr, input logic [31:0] wdata, input logic [3:0] sel,
	input logic reg_we, input logic [4:0] reg_waddr, input logic [31:0] reg_wdata);
	if (is_b)
	begin
		b_op_i <= op;
		b_ce_i <= ce;
		b_we_i <= we;
		b_addr_i <= addr;
		b_wdata_i <= wdata;
		b_sel_i <= sel;
		b_reg_we_i <= reg_we;
		b_reg_waddr_i <= reg_waddr;
		b_reg_wdata_i <= reg_wdata;
	end else begin
		a_op_i <= op;
		a_ce_i <= ce;
		a_we_i <= we;
		a_addr_i <= addr;
		a_wdata_i <= wdata;
		a_sel_i <= sel;
		a_reg_we_i <= reg_we;
		a_reg_waddr_i <= reg_waddr;
		a_reg_wdata_i <= reg_wdata;
	end
endtask

// Returns on a rising edge that follows a cycle with stall_o low
task automatic wait_ready();
	@(negedge clk);
	while (stall_o)
	begin
		@(negedge clk);
	end
	@(posedge clk);
endtask

task automatic alu_req(input logic a_we, input logic [4:0] a_addr, input logic [31:0] a_data,
	input logic b_we, input logic [4:0] b_addr, input logic [31:0] b_data);
	if (a_we)
	begin
		expect_write(1'b0, cpu_pkg::OP_NONE, a_addr, a_data);
	end
	if (b_we)
	begin
		expect_write(1'b1, cpu_pkg::OP_NONE, b_addr, b_data);
	end
	wait_ready();
	drive_pipe(1'b0, cpu_pkg::OP_NONE, 1'b0, 1'b0, '0, '0, '0, a_we, a_addr, a_data);
	drive_pipe(1'b1, cpu_pkg::OP_NONE, 1'b0, 1'b0, '0, '0, '0, b_we, b_addr, b_data);
endtask

// One memory request on one pipe, with an optional plain register write on the other
task automatic mem_req(input logic use_b, input cpu_pkg::mem_op_e op, input logic [31:0] addr,
	input logic [31:0] data, input logic other_we);
	logic [3:0] mask;
	logic [31:0] wdata;
	logic [31:0] result;
	logic [31:0] r;
	logic [31:0] other_data;
	logic we;
	logic reg_we;
	mask = lane_mask(op, addr[1:0]);
	we = is_store(op);
	reg_we = !we || op == cpu_pkg::OP_SC;
	r = next_rand();
	other_data = next_rand();
	case (op)
		cpu_pkg::OP_SB: wdata = {4{data[7:0]}};
		cpu_pkg::OP_SH: wdata = {2{data[15:0]}};
		default: wdata = data; // Old rt for LWL and LWR
	endcase
	result = '0;
	if (op == cpu_pkg::OP_SC)
	begin
		result = {31'd0, ll_model};
		if (ll_model)
		begin
			store_model(addr, wdata, mask);
			accesses++;
		end
		ll_model = 1'b0;
	end else if (we) begin
		store_model(addr, wdata, mask);
		accesses++;
	end else begin
		result = ref_load(op, addr, data, mask);
		accesses++;
		if (op == cpu_pkg::OP_LL)
		begin
			ll_model = 1'b1;
		end
	end
	if (reg_we)
	begin
		expect_write(use_b, op, r[4:0], result);
	end
	if (other_we)
	begin
		expect_write(!use_b, cpu_pkg::OP_NONE, r[9:5], other_data);
	end
	wait_ready();
	drive_pipe(use_b, op, 1'b1, we, addr, wdata, mask, reg_we, r[4:0], '0);
	drive_pipe(!use_b, cpu_pkg::OP_NONE, 1'b0, 1'b0, '0, '0, '0, other_we, r[9:5], other_data);
endtask

task automatic check_wb(input string sig, input cpu_pkg::mem_op_e op,
	input logic [cpu_pkg::REG_ADDR_W-1:0] exp_addr,
	input logic [cpu_pkg::REG_ADDR_W-1:0] got_addr,
	input logic [cpu_pkg::WORD_W-1:0] exp_data,
	input logic [cpu_pkg::WORD_W-1:0] got_data);
	if (got_addr !== exp_addr)
	begin
		$display("Error: %s_waddr_o (%s) expected %h got %h", sig, op.name(), exp_addr, got_addr);
		value_errs++;
	end
	if (got_data !== exp_data)
	begin
		$display("Error: %s_wdata_o (%s) expected %h got %h", sig, op.name(), exp_data, got_data);
		value_errs++;
	end
endtask

task automatic check_ll(input string sig, input logic [cpu_pkg::REG_ADDR_W-1:0] exp_addr,
	input logic [cpu_pkg::REG_ADDR_W-1:0] got_addr, input logic exp_bit,
	input logic [cpu_pkg::WORD_W-1:0] got_data);
	if (got_addr !== exp_addr)
	begin
		$display("Error: %s_waddr_o (OP_SC) expected %h got %h", sig, exp_addr, got_addr);
		sc_errs++;
	end
	if (got_data !== {31'd0, exp_bit})
	begin
		$display("Error: %s_wdata_o (SC result) expected %h got %h", sig, {31'd0, exp_bit},
			got_data);
		sc_errs++;
	end
endtask

task automatic compare_pipe(input logic is_b, input logic [cpu_pkg::REG_ADDR_W-1:0] waddr,
	input logic [cpu_pkg::WORD_W-1:0] wdata);
	wb_exp_t e;
	string sig;
	int depth;
	sig = is_b ? "wb_b" : "wb_a";
	depth = is_b ? exp_b.size() : exp_a.size();
	if (depth == 0)
	begin
		$display("%s wrote register %0d although no write was expected", sig, waddr);
		flow_errs++;
	end else begin
		if (is_b)
		begin
			e = exp_b.pop_front();
		end else begin
			e = exp_a.pop_front();
		end
		if (e.op == cpu_pkg::OP_SC)
		begin
			check_ll(sig, e.waddr, waddr, e.wdata[0], wdata);
		end else begin
			check_wb(sig, e.op, e.waddr, waddr, e.wdata, wdata);
		end
	end
endtask

// Outputs are registered, so the falling edge sees them settled
always @(negedge clk)
begin
	if (!rst)
	begin
		if (wb_a_we_o)
		begin
			compare_pipe(1'b0, wb_a_waddr_o, wb_a_wdata_o);
		end
		if (wb_b_we_o)
		begin
			compare_pipe(1'b1, wb_b_waddr_o, wb_b_wdata_o);
		end
		if (stall_o)
		begin
			stall_pulses++;
			if (stall_prev)
			begin
				$display("stall_o stayed high for more than one cycle");
				flow_errs++;
			end
		end
		stall_prev = stall_o;
	end
end

initial
begin
	while (cycles < CYCLE_LIMIT)
	begin
		@(posedge clk);
		cycles++;
	end
	$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
	$display("Test failed");
	$finish;
end

initial
begin
	logic [31:0] r;
	cpu_pkg::mem_op_e op;
	logic [31:0] addr;
	int drain;
	drive_pipe(1'b0, cpu_pkg::OP_NONE, 1'b0, 1'b0, '0, '0, '0, 1'b0, '0, '0);
	drive_pipe(1'b1, cpu_pkg::OP_NONE, 1'b0, 1'b0, '0, '0, '0, 1'b0, '0, '0);
	rst <= 1'b1;
	repeat (8) @(posedge clk);
	rst <= 1'b0;

	for (int i = 0; i < ALU_REQS; i++)
	begin
		r = next_rand();
		alu_req(r[0], r[5:1], next_rand(), r[6], r[11:7], next_rand());
	end

	for (int w = 0; w < 16; w++)
	begin
		r = next_rand();
		mem_req(r[0], cpu_pkg::OP_SW, w * 4, next_rand(), r[1]);
	end
	mem_req(1'b0, cpu_pkg::OP_SW, 32'd80, 32'h80ff7f01, 1'b1); // Mixed sign bytes and halves
	mem_req(1'b1, cpu_pkg::OP_SW, 32'd84, 32'h13579bdf, 1'b0);

	for (int i = 0; i < STORE_REQS; i++)
	begin
		r = next_rand();
		op = op_from_index(5 + r % 3);
		mem_req(r[4], op, {26'd0, r[11:8], pick_offset(op)}, next_rand(), r[5]);
	end

	for (int off = 0; off < 4; off++)
	begin
		mem_req(off[0], cpu_pkg::OP_LB, 32'd80 + off, '0, 1'b1);
		mem_req(!off[0], cpu_pkg::OP_LBU, 32'd80 + off, '0, 1'b0);
	end
	for (int off = 0; off < 4; off += 2)
	begin
		mem_req(1'b0, cpu_pkg::OP_LH, 32'd80 + off, '0, 1'b1);
		mem_req(1'b1, cpu_pkg::OP_LHU, 32'd80 + off, '0, 1'b1);
	end

	for (int i = 0; i < LOAD_REQS; i++)
	begin
		r = next_rand();
		op = op_from_index(r % 5);
		mem_req(r[4], op, {26'd0, r[11:8], pick_offset(op)}, '0, r[5]);
	end

	for (int off = 0; off < 4; off++)
	begin
		mem_req(off[0], cpu_pkg::OP_LWL, 32'd80 + off, next_rand(), 1'b1);
		mem_req(off[1], cpu_pkg::OP_LWR, 32'd80 + off, next_rand(), 1'b0);
	end
	for (int i = 0; i < 8; i++)
	begin
		r = next_rand();
		op = r[2] ? cpu_pkg::OP_LWL : cpu_pkg::OP_LWR;
		mem_req(r[3], op, {26'd0, r[11:8], r[1:0]}, next_rand(), r[4]);
	end

	mem_req(1'b0, cpu_pkg::OP_LL, 32'd84, '0, 1'b0);
	mem_req(1'b1, cpu_pkg::OP_SC, 32'd84, 32'hcafef00d, 1'b1); // Reservation still held
	mem_req(1'b0, cpu_pkg::OP_SC, 32'd84, 32'h0badbeef, 1'b1);
	mem_req(1'b1, cpu_pkg::OP_LW, 32'd84, '0, 1'b0);

	for (int i = 0; i < MIX_REQS; i++)
	begin
		r = next_rand();
		op = op_from_index(r % 8);
		mem_req(r[4], op, {26'd0, r[11:8], pick_offset(op)}, next_rand(), 1'b1);
	end

	wait_ready();
	drive_pipe(1'b0, cpu_pkg::OP_NONE, 1'b0, 1'b0, '0, '0, '0, 1'b0, '0, '0);
	drive_pipe(1'b1, cpu_pkg::OP_NONE, 1'b0, 1'b0, '0, '0, '0, 1'b0, '0, '0);
	drain = 0;
	while ((exp_a.size() != 0 || exp_b.size() != 0) && drain < 4) // Last request needs two edges
	begin
		@(negedge clk);
		drain++;
	end
	repeat (4) @(negedge clk); // Room for any repeated write to show up

	if (stall_pulses != accesses)
	begin
		$display("Error: stall_o pulse count expected %h got %h", accesses, stall_pulses);
		flow_errs++;
	end
	if (exp_a.size() != 0 || exp_b.size() != 0)
	begin
		$display("%0d writes on pipe a and %0d on pipe b never came out", exp_a.size(),
			exp_b.size());
		flow_errs++;
	end
	$display("Checks done with %0d value errors, %0d SC result errors and %0d other errors",
		value_errs, sc_errs, flow_errs);
	if (value_errs == 0 && sc_errs == 0 && flow_errs == 0)
	begin
		$display("Test passed");
	end else begin
		$display("Test failed");
	end
	$finish;
end

endmodule

// File: flist.f
verilog/cpu_pkg.sv
verilog/mem_stage_reg.sv
verilog/mem_access.sv
verilog/data_ram.sv
verilog/wb_reg.sv
verilog/mem_top.sv
bench/tb_mem_top.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the memory stage testbench with Verilator, runs it and checks the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_mem_top \
	-f flist.f \
	-o sim_tb_mem_top

./obj_dir/sim_tb_mem_top | tee sim.log

grep -q "^Test passed$" sim.log
echo "Simulation log shows a passing run"
